// ==== isa_pkg.sv ====
// --------------------------------------------------------------------
// RV32I encoding constants
// Opcodes, funct fields and the basic word and index types used by
// the decoder and the register file
// --------------------------------------------------------------------

`default_nettype none

package isa_pkg;

  // ------------------------------------------------------------------
  // basic types
  // ------------------------------------------------------------------
  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [31:0] instr_t;

  localparam int unsigned NrRegs = 32;

  // ------------------------------------------------------------------
  // major opcodes
  // ------------------------------------------------------------------
  localparam logic [6:0] OpcodeOp    = 7'b0110011;
  localparam logic [6:0] OpcodeOpImm = 7'b0010011;
  localparam logic [6:0] OpcodeLui   = 7'b0110111;

  // funct3 select for the supported ALU subset
  localparam logic [2:0] Funct3Add = 3'b000;
  localparam logic [2:0] Funct3Xor = 3'b100;
  localparam logic [2:0] Funct3Or  = 3'b110;
  localparam logic [2:0] Funct3And = 3'b111;

  // only funct7 besides zero that is accepted
  localparam logic [6:0] Funct7Sub = 7'b0100000;

endpackage

`default_nettype wire

// ==== core_pkg.sv ====
// --------------------------------------------------------------------
// Core pipeline definitions
// ALU operation encoding, program counter type and the default
// width of the retire counters
// --------------------------------------------------------------------

`default_nettype none

package core_pkg;

  // program counter travels with every instruction
  typedef logic [31:0] pc_t;

  // ------------------------------------------------------------------
  // ALU operations
  // ------------------------------------------------------------------
  // pass_b forwards operand b unchanged for LUI
  typedef enum logic [2:0] {
    AluAdd   = 3'd0,
    AluSub   = 3'd1,
    AluAnd   = 3'd2,
    AluOr    = 3'd3,
    AluXor   = 3'd4,
    AluPassB = 3'd5
  } alu_op_e;

  // instret and illegal counters
  localparam int unsigned DefaultCntWidth = 32;

endpackage

`default_nettype wire

// ==== id_stage.sv ====
// --------------------------------------------------------------------
// Instruction decode stage
// Accepts fetched words, decodes the RV32I ALU subset and holds one
// decoded instruction for the issue stage
// --------------------------------------------------------------------

`default_nettype none

module id_stage (
  input  logic                clk_i,
  input  logic                rst_ni,
  // fetch port
  input  logic                fetch_valid_i,
  output logic                fetch_ready_o,
  input  isa_pkg::instr_t     fetch_instr_i,
  input  core_pkg::pc_t       fetch_pc_i,
  // towards issue
  output logic                issue_valid_o,
  input  logic                issue_ready_i,
  output core_pkg::pc_t       issue_pc_o,
  output core_pkg::alu_op_e   issue_op_o,
  output isa_pkg::reg_addr_t  issue_rd_o,
  output isa_pkg::reg_addr_t  issue_rs1_o,
  output isa_pkg::reg_addr_t  issue_rs2_o,
  output isa_pkg::xlen_t      issue_imm_o,
  output logic                issue_use_imm_o,
  output logic                issue_use_rs1_o,
  output logic                issue_illegal_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  core_pkg::alu_op_e f3_op;
  logic              f3_legal;
  core_pkg::alu_op_e op_d;
  isa_pkg::xlen_t    imm_d;
  logic              use_imm_d;
  logic              use_rs1_d;
  logic              illegal_d;

  logic valid_q;
  logic accept;

  assign opcode = fetch_instr_i[6:0];
  assign funct3 = fetch_instr_i[14:12];
  assign funct7 = fetch_instr_i[31:25];

  // ------------------------------------------------------------------
  // decoder
  // ------------------------------------------------------------------
  always_comb begin
    // funct3 mapping is shared by OP and OP-IMM
    f3_legal = 1'b1;
    case (funct3)
      isa_pkg::Funct3Add: f3_op = core_pkg::AluAdd;
      isa_pkg::Funct3Xor: f3_op = core_pkg::AluXor;
      isa_pkg::Funct3Or:  f3_op = core_pkg::AluOr;
      isa_pkg::Funct3And: f3_op = core_pkg::AluAnd;
      default: begin
        f3_op    = core_pkg::AluAdd;
        f3_legal = 1'b0;
      end
    endcase

    op_d      = f3_op;
    imm_d     = {{20{fetch_instr_i[31]}}, fetch_instr_i[31:20]};
    use_imm_d = 1'b1;
    use_rs1_d = 1'b1;
    illegal_d = 1'b1;

    case (opcode)
      isa_pkg::OpcodeOp: begin
        use_imm_d = 1'b0;
        if (funct7 == 7'b0) begin
          illegal_d = ~f3_legal;
        end else if (funct7 == isa_pkg::Funct7Sub && funct3 == isa_pkg::Funct3Add) begin
          op_d      = core_pkg::AluSub;
          illegal_d = 1'b0;
        end
      end
      isa_pkg::OpcodeOpImm: begin
        illegal_d = ~f3_legal;
      end
      isa_pkg::OpcodeLui: begin
        op_d      = core_pkg::AluPassB;
        imm_d     = {fetch_instr_i[31:12], 12'b0};
        use_rs1_d = 1'b0;
        illegal_d = 1'b0;
      end
      default: ;
    endcase

    // illegal words read no register, so they never wait on a hazard
    if (illegal_d) begin
      use_rs1_d = 1'b0;
      use_imm_d = 1'b1;
    end
  end

  // ------------------------------------------------------------------
  // pipeline register
  // ------------------------------------------------------------------
  assign fetch_ready_o = ~valid_q | issue_ready_i;
  assign accept        = fetch_valid_i & fetch_ready_o;
  assign issue_valid_o = valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (issue_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      issue_pc_o      <= fetch_pc_i;
      issue_op_o      <= op_d;
      issue_rd_o      <= fetch_instr_i[11:7];
      issue_rs1_o     <= fetch_instr_i[19:15];
      issue_rs2_o     <= fetch_instr_i[24:20];
      issue_imm_o     <= imm_d;
      issue_use_imm_o <= use_imm_d;
      issue_use_rs1_o <= use_rs1_d;
      issue_illegal_o <= illegal_d;
    end
  end

endmodule

`default_nettype wire

// ==== issue_stage.sv ====
// --------------------------------------------------------------------
// Issue stage
// Register file, per-register pending-write scoreboard and operand
// read; holds a decoded instruction until its registers are free
// --------------------------------------------------------------------

`default_nettype none

module issue_stage (
  input  logic                clk_i,
  input  logic                rst_ni,
  // from decode
  input  logic                issue_valid_i,
  output logic                id_ready_o,
  input  core_pkg::pc_t       issue_pc_i,
  input  core_pkg::alu_op_e   issue_op_i,
  input  isa_pkg::reg_addr_t  issue_rd_i,
  input  isa_pkg::reg_addr_t  issue_rs1_i,
  input  isa_pkg::reg_addr_t  issue_rs2_i,
  input  isa_pkg::xlen_t      issue_imm_i,
  input  logic                issue_use_imm_i,
  input  logic                issue_use_rs1_i,
  input  logic                issue_illegal_i,
  // towards execute
  output logic                ex_valid_o,
  input  logic                ex_ready_i,
  output core_pkg::pc_t       ex_pc_o,
  output core_pkg::alu_op_e   ex_op_o,
  output isa_pkg::reg_addr_t  ex_rd_o,
  output isa_pkg::xlen_t      ex_a_o,
  output isa_pkg::xlen_t      ex_b_o,
  output logic                ex_illegal_o,
  // writeback from commit
  input  logic                wb_en_i,
  input  isa_pkg::reg_addr_t  wb_rd_i,
  input  isa_pkg::xlen_t      wb_data_i,
  input  logic                retire_i
);

  isa_pkg::xlen_t             rf_q [isa_pkg::NrRegs];
  logic [isa_pkg::NrRegs-1:0] pending_q;

  isa_pkg::xlen_t rs1_data;
  isa_pkg::xlen_t rs2_data;
  logic           writes_rd;
  logic           hazard;
  logic           fire;
  logic           valid_q;

  // ------------------------------------------------------------------
  // register file
  // ------------------------------------------------------------------
  // x0 is never written and always reads as zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < isa_pkg::NrRegs; i++) begin
        rf_q[i] <= '0;
      end
    end else if (wb_en_i && wb_rd_i != '0) begin
      rf_q[wb_rd_i] <= wb_data_i;
    end
  end

  assign rs1_data = (issue_rs1_i == '0) ? '0 : rf_q[issue_rs1_i];
  assign rs2_data = (issue_rs2_i == '0) ? '0 : rf_q[issue_rs2_i];

  // ------------------------------------------------------------------
  // scoreboard
  // ------------------------------------------------------------------
  assign writes_rd = ~issue_illegal_i & (issue_rd_i != '0);

  // pending_q is not bypassed; a register written back on this edge is
  // read one cycle later from the register file.
  // rd is checked as well, so an older writer cannot clear the bit of
  // a younger one to the same register
  assign hazard = (issue_use_rs1_i  & pending_q[issue_rs1_i])
                | (~issue_use_imm_i & pending_q[issue_rs2_i])
                | (writes_rd        & pending_q[issue_rd_i]);

  assign id_ready_o = ~hazard & (~valid_q | ex_ready_i);
  assign fire       = issue_valid_i & id_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= '0;
    end else begin
      if (retire_i) begin
        pending_q[wb_rd_i] <= 1'b0;
      end
      // a new writer wins over a retire on the same edge
      if (fire && writes_rd) begin
        pending_q[issue_rd_i] <= 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------
  // issue register
  // ------------------------------------------------------------------
  assign ex_valid_o = valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (fire) begin
      valid_q <= 1'b1;
    end else if (ex_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire) begin
      ex_pc_o      <= issue_pc_i;
      ex_op_o      <= issue_op_i;
      ex_rd_o      <= issue_rd_i;
      ex_a_o       <= issue_use_rs1_i ? rs1_data : '0;
      ex_b_o       <= issue_use_imm_i ? issue_imm_i : rs2_data;
      ex_illegal_o <= issue_illegal_i;
    end
  end

endmodule

`default_nettype wire

// ==== ex_stage.sv ====
// --------------------------------------------------------------------
// Execute stage
// Integer ALU with one result register towards commit
// --------------------------------------------------------------------

`default_nettype none

module ex_stage (
  input  logic                clk_i,
  input  logic                rst_ni,
  // from issue
  input  logic                ex_valid_i,
  output logic                issue_ready_o,
  input  core_pkg::pc_t       ex_pc_i,
  input  core_pkg::alu_op_e   ex_op_i,
  input  isa_pkg::reg_addr_t  ex_rd_i,
  input  isa_pkg::xlen_t      ex_a_i,
  input  isa_pkg::xlen_t      ex_b_i,
  input  logic                ex_illegal_i,
  // towards commit
  output logic                commit_valid_o,
  input  logic                commit_ready_i,
  output core_pkg::pc_t       commit_pc_o,
  output isa_pkg::reg_addr_t  commit_rd_o,
  output isa_pkg::xlen_t      commit_data_o,
  output logic                commit_illegal_o
);

  isa_pkg::xlen_t alu_res;
  logic           fire;
  logic           valid_q;

  // ------------------------------------------------------------------
  // ALU
  // ------------------------------------------------------------------
  // 32-bit wraparound on add and sub
  always_comb begin
    case (ex_op_i)
      core_pkg::AluAdd:   alu_res = ex_a_i + ex_b_i;
      core_pkg::AluSub:   alu_res = ex_a_i - ex_b_i;
      core_pkg::AluAnd:   alu_res = ex_a_i & ex_b_i;
      core_pkg::AluOr:    alu_res = ex_a_i | ex_b_i;
      core_pkg::AluXor:   alu_res = ex_a_i ^ ex_b_i;
      core_pkg::AluPassB: alu_res = ex_b_i;
      default:            alu_res = '0;
    endcase
  end

  // ------------------------------------------------------------------
  // result register
  // ------------------------------------------------------------------
  assign issue_ready_o  = ~valid_q | commit_ready_i;
  assign fire           = ex_valid_i & issue_ready_o;
  assign commit_valid_o = valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (fire) begin
      valid_q <= 1'b1;
    end else if (commit_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire) begin
      commit_pc_o      <= ex_pc_i;
      commit_rd_o      <= ex_rd_i;
      // illegal instructions carry a zero result
      commit_data_o    <= ex_illegal_i ? '0 : alu_res;
      commit_illegal_o <= ex_illegal_i;
    end
  end

endmodule

`default_nettype wire

// ==== commit_stage.sv ====
// --------------------------------------------------------------------
// Commit stage
// Presents the oldest result on the commit port, drives register
// writeback and scoreboard release, counts retired instructions
// --------------------------------------------------------------------

`default_nettype none

module commit_stage #(
  parameter int unsigned CntWidth = core_pkg::DefaultCntWidth
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // from execute
  input  logic                 ex_valid_i,
  output logic                 ex_ready_o,
  input  core_pkg::pc_t        ex_pc_i,
  input  isa_pkg::reg_addr_t   ex_rd_i,
  input  isa_pkg::xlen_t       ex_data_i,
  input  logic                 ex_illegal_i,
  // commit port
  output logic                 commit_valid_o,
  input  logic                 commit_ready_i,
  output core_pkg::pc_t        commit_pc_o,
  output isa_pkg::reg_addr_t   commit_rd_o,
  output isa_pkg::xlen_t       commit_wdata_o,
  output logic                 commit_illegal_o,
  // writeback and scoreboard release
  output logic                 wb_en_o,
  output isa_pkg::reg_addr_t   wb_rd_o,
  output isa_pkg::xlen_t       wb_data_o,
  output logic                 retire_o,
  // retire counters
  output logic [CntWidth-1:0]  instret_o,
  output logic [CntWidth-1:0]  illegal_cnt_o
);

  logic retire;

  // commit port is a straight view of the EX result register
  assign commit_valid_o   = ex_valid_i;
  assign commit_pc_o      = ex_pc_i;
  assign commit_rd_o      = ex_rd_i;
  assign commit_wdata_o   = ex_data_i;
  assign commit_illegal_o = ex_illegal_i;
  assign ex_ready_o       = commit_ready_i;

  assign retire = ex_valid_i & commit_ready_i;

  // ------------------------------------------------------------------
  // writeback
  // ------------------------------------------------------------------
  assign wb_en_o   = retire & ~ex_illegal_i;
  assign wb_data_o = ex_data_i;
  assign retire_o  = retire;
  // illegal ones release x0, whose bit is never set
  assign wb_rd_o   = ex_illegal_i ? '0 : ex_rd_i;

  // ------------------------------------------------------------------
  // counters wrap at CntWidth
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instret_o     <= '0;
      illegal_cnt_o <= '0;
    end else if (retire) begin
      instret_o <= instret_o + 1'b1;
      if (ex_illegal_i) begin
        illegal_cnt_o <= illegal_cnt_o + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== core_top.sv ====
// --------------------------------------------------------------------
// Core top level
// In-order ID, issue, EX and commit stages between a fetch port and
// a commit port
// --------------------------------------------------------------------

`default_nettype none

module core_top #(
  parameter int unsigned CntWidth = core_pkg::DefaultCntWidth
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // fetch port
  input  logic                 fetch_valid_i,
  output logic                 fetch_ready_o,
  input  isa_pkg::instr_t      fetch_instr_i,
  input  core_pkg::pc_t        fetch_pc_i,
  // commit port
  output logic                 commit_valid_o,
  input  logic                 commit_ready_i,
  output core_pkg::pc_t        commit_pc_o,
  output isa_pkg::reg_addr_t   commit_rd_o,
  output isa_pkg::xlen_t       commit_wdata_o,
  output logic                 commit_illegal_o,
  output logic [CntWidth-1:0]  instret_o,
  output logic [CntWidth-1:0]  illegal_cnt_o
);

  // ------------------------------------------------------------------
  // ID <-> issue
  // ------------------------------------------------------------------
  logic               id_valid;
  logic               id_ready;
  core_pkg::pc_t      id_pc;
  core_pkg::alu_op_e  id_op;
  isa_pkg::reg_addr_t id_rd;
  isa_pkg::reg_addr_t id_rs1;
  isa_pkg::reg_addr_t id_rs2;
  isa_pkg::xlen_t     id_imm;
  logic               id_use_imm;
  logic               id_use_rs1;
  logic               id_illegal;

  // ------------------------------------------------------------------
  // issue <-> EX
  // ------------------------------------------------------------------
  logic               iss_valid;
  logic               iss_ready;
  core_pkg::pc_t      iss_pc;
  core_pkg::alu_op_e  iss_op;
  isa_pkg::reg_addr_t iss_rd;
  isa_pkg::xlen_t     iss_a;
  isa_pkg::xlen_t     iss_b;
  logic               iss_illegal;

  // ------------------------------------------------------------------
  // EX <-> commit, commit -> issue
  // ------------------------------------------------------------------
  logic               ex_valid;
  logic               ex_ready;
  core_pkg::pc_t      ex_pc;
  isa_pkg::reg_addr_t ex_rd;
  isa_pkg::xlen_t     ex_data;
  logic               ex_illegal;
  logic               wb_en;
  isa_pkg::reg_addr_t wb_rd;
  isa_pkg::xlen_t     wb_data;
  logic               retire;

  id_stage id_stage_i (
    .clk_i           ( clk_i         ),
    .rst_ni          ( rst_ni        ),
    .fetch_valid_i   ( fetch_valid_i ),
    .fetch_ready_o   ( fetch_ready_o ),
    .fetch_instr_i   ( fetch_instr_i ),
    .fetch_pc_i      ( fetch_pc_i    ),
    .issue_valid_o   ( id_valid      ),
    .issue_ready_i   ( id_ready      ),
    .issue_pc_o      ( id_pc         ),
    .issue_op_o      ( id_op         ),
    .issue_rd_o      ( id_rd         ),
    .issue_rs1_o     ( id_rs1        ),
    .issue_rs2_o     ( id_rs2        ),
    .issue_imm_o     ( id_imm        ),
    .issue_use_imm_o ( id_use_imm    ),
    .issue_use_rs1_o ( id_use_rs1    ),
    .issue_illegal_o ( id_illegal    )
  );

  issue_stage issue_stage_i (
    .clk_i           ( clk_i       ),
    .rst_ni          ( rst_ni      ),
    .issue_valid_i   ( id_valid    ),
    .id_ready_o      ( id_ready    ),
    .issue_pc_i      ( id_pc       ),
    .issue_op_i      ( id_op       ),
    .issue_rd_i      ( id_rd       ),
    .issue_rs1_i     ( id_rs1      ),
    .issue_rs2_i     ( id_rs2      ),
    .issue_imm_i     ( id_imm      ),
    .issue_use_imm_i ( id_use_imm  ),
    .issue_use_rs1_i ( id_use_rs1  ),
    .issue_illegal_i ( id_illegal  ),
    .ex_valid_o      ( iss_valid   ),
    .ex_ready_i      ( iss_ready   ),
    .ex_pc_o         ( iss_pc      ),
    .ex_op_o         ( iss_op      ),
    .ex_rd_o         ( iss_rd      ),
    .ex_a_o          ( iss_a       ),
    .ex_b_o          ( iss_b       ),
    .ex_illegal_o    ( iss_illegal ),
    .wb_en_i         ( wb_en       ),
    .wb_rd_i         ( wb_rd       ),
    .wb_data_i       ( wb_data     ),
    .retire_i        ( retire      )
  );

  ex_stage ex_stage_i (
    .clk_i            ( clk_i       ),
    .rst_ni           ( rst_ni      ),
    .ex_valid_i       ( iss_valid   ),
    .issue_ready_o    ( iss_ready   ),
    .ex_pc_i          ( iss_pc      ),
    .ex_op_i          ( iss_op      ),
    .ex_rd_i          ( iss_rd      ),
    .ex_a_i           ( iss_a       ),
    .ex_b_i           ( iss_b       ),
    .ex_illegal_i     ( iss_illegal ),
    .commit_valid_o   ( ex_valid    ),
    .commit_ready_i   ( ex_ready    ),
    .commit_pc_o      ( ex_pc       ),
    .commit_rd_o      ( ex_rd       ),
    .commit_data_o    ( ex_data     ),
    .commit_illegal_o ( ex_illegal  )
  );

  commit_stage #(
    .CntWidth ( CntWidth )
  ) commit_stage_i (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .ex_valid_i       ( ex_valid         ),
    .ex_ready_o       ( ex_ready         ),
    .ex_pc_i          ( ex_pc            ),
    .ex_rd_i          ( ex_rd            ),
    .ex_data_i        ( ex_data          ),
    .ex_illegal_i     ( ex_illegal       ),
    .commit_valid_o   ( commit_valid_o   ),
    .commit_ready_i   ( commit_ready_i   ),
    .commit_pc_o      ( commit_pc_o      ),
    .commit_rd_o      ( commit_rd_o      ),
    .commit_wdata_o   ( commit_wdata_o   ),
    .commit_illegal_o ( commit_illegal_o ),
    .wb_en_o          ( wb_en            ),
    .wb_rd_o          ( wb_rd            ),
    .wb_data_o        ( wb_data          ),
    .retire_o         ( retire           ),
    .instret_o        ( instret_o        ),
    .illegal_cnt_o    ( illegal_cnt_o    )
  );

endmodule

`default_nettype wire

// ==== core_tb_table.svh ====
// --------------------------------------------------------------------
// Core testbench program
// Instruction words with the values each one must retire with, in
// program order, starting from all-zero registers
// --------------------------------------------------------------------

`ifndef CORE_TB_TABLE_SVH
`define CORE_TB_TABLE_SVH

localparam int unsigned NumRows = 20;

// columns: index, instruction word, pc, expected rd, expected write data,
// expected illegal flag
task automatic fill_table();
  // immediates from x0
  add_row( 0, 32'h00500093, 32'h8000_0000, 5'd1,  32'h0000_0005, 1'b0); // addi x1,x0,5
  add_row( 1, 32'hFFD00113, 32'h8000_0004, 5'd2,  32'hFFFF_FFFD, 1'b0); // addi x2,x0,-3
  add_row( 2, 32'h7FF07193, 32'h8000_0008, 5'd3,  32'h0000_0000, 1'b0); // andi x3,x0,0x7ff
  add_row( 3, 32'hFF006213, 32'h8000_000C, 5'd4,  32'hFFFF_FFF0, 1'b0); // ori x4,x0,-16
  add_row( 4, 32'h55504293, 32'h8000_0010, 5'd5,  32'h0000_0555, 1'b0); // xori x5,x0,0x555
  add_row( 5, 32'h12345337, 32'h8000_0014, 5'd6,  32'h1234_5000, 1'b0); // lui x6,0x12345
  // back-to-back register dependencies
  add_row( 6, 32'h002083B3, 32'h8000_0018, 5'd7,  32'h0000_0002, 1'b0); // add x7,x1,x2
  add_row( 7, 32'h40138433, 32'h8000_001C, 5'd8,  32'hFFFF_FFFD, 1'b0); // sub x8,x7,x1
  add_row( 8, 32'h004474B3, 32'h8000_0020, 5'd9,  32'hFFFF_FFF0, 1'b0); // and x9,x8,x4
  add_row( 9, 32'h0054E533, 32'h8000_0024, 5'd10, 32'hFFFF_FFF5, 1'b0); // or x10,x9,x5
  add_row(10, 32'h006545B3, 32'h8000_0028, 5'd11, 32'hEDCB_AFF5, 1'b0); // xor x11,x10,x6
  add_row(11, 32'h00158593, 32'h8000_002C, 5'd11, 32'hEDCB_AFF6, 1'b0); // addi x11,x11,1
  // write to x0, then read it back
  add_row(12, 32'h06408013, 32'h8000_0030, 5'd0,  32'h0000_0069, 1'b0); // addi x0,x1,100
  add_row(13, 32'h00100633, 32'h8000_0034, 5'd12, 32'h0000_0005, 1'b0); // add x12,x0,x1
  // unsupported encodings retire as illegal
  add_row(14, 32'h0000A683, 32'h8000_0038, 5'd13, 32'h0000_0000, 1'b1); // lw x13,0(x1)
  add_row(15, 32'h00208463, 32'h8000_003C, 5'd8,  32'h0000_0000, 1'b1); // beq x1,x2,8
  add_row(16, 32'h00209693, 32'h8000_0040, 5'd13, 32'h0000_0000, 1'b1); // slli x13,x1,2
  // x13 and x8 must be untouched by the illegal rows
  add_row(17, 32'h0086E733, 32'h8000_0044, 5'd14, 32'hFFFF_FFFD, 1'b0); // or x14,x13,x8
  add_row(18, 32'hFFFFF7B7, 32'h8000_0048, 5'd15, 32'hFFFF_F000, 1'b0); // lui x15,0xfffff
  add_row(19, 32'h40F007B3, 32'h8000_004C, 5'd15, 32'h0000_1000, 1'b0); // sub x15,x0,x15
endtask

`endif

// ==== core_tb.sv ====
// --------------------------------------------------------------------
// Core testbench
// Streams the program table through the fetch port under random
// commit back-pressure and checks every retired instruction
// --------------------------------------------------------------------

`default_nettype none

module core_tb;

  logic        clk_i;
  logic        rst_ni;
  logic        fetch_valid_i;
  logic        fetch_ready_o;
  logic [31:0] fetch_instr_i;
  logic [31:0] fetch_pc_i;
  logic        commit_valid_o;
  logic        commit_ready_i;
  logic [31:0] commit_pc_o;
  logic [4:0]  commit_rd_o;
  logic [31:0] commit_wdata_o;
  logic        commit_illegal_o;
  logic [31:0] instret_o;
  logic [31:0] illegal_cnt_o;

  `include "core_tb_table.svh"

  localparam int unsigned MaxCycles = NumRows * 20 + 50;

  // expected stream
  logic [31:0] row_instr   [NumRows];
  logic [31:0] row_pc      [NumRows];
  logic [4:0]  row_rd      [NumRows];
  logic [31:0] row_wdata   [NumRows];
  logic        row_illegal [NumRows];

  int unsigned num_illegal;
  int unsigned mismatch_cnt;
  int unsigned protocol_cnt;
  int unsigned retired;
  int unsigned cycles;

  core_top #(
    .CntWidth ( 32 )
  ) core_top_i (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .fetch_valid_i    ( fetch_valid_i    ),
    .fetch_ready_o    ( fetch_ready_o    ),
    .fetch_instr_i    ( fetch_instr_i    ),
    .fetch_pc_i       ( fetch_pc_i       ),
    .commit_valid_o   ( commit_valid_o   ),
    .commit_ready_i   ( commit_ready_i   ),
    .commit_pc_o      ( commit_pc_o      ),
    .commit_rd_o      ( commit_rd_o      ),
    .commit_wdata_o   ( commit_wdata_o   ),
    .commit_illegal_o ( commit_illegal_o ),
    .instret_o        ( instret_o        ),
    .illegal_cnt_o    ( illegal_cnt_o    )
  );

  task automatic add_row(
    input int unsigned idx,
    input logic [31:0] instr,
    input logic [31:0] pc,
    input logic [4:0]  rd,
    input logic [31:0] wdata,
    input logic        illegal
  );
    row_instr[idx]   = instr;
    row_pc[idx]      = pc;
    row_rd[idx]      = rd;
    row_wdata[idx]   = wdata;
    row_illegal[idx] = illegal;
    if (illegal) begin
      num_illegal++;
    end
  endtask

  task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
      mismatch_cnt++;
    end
  endtask

  // ------------------------------------------------------------------
  // clock and reset, fetch driver
  // ------------------------------------------------------------------
  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    rst_ni         = 1'b0;
    fetch_valid_i  = 1'b0;
    fetch_instr_i  = '0;
    fetch_pc_i     = '0;
    commit_ready_i = 1'b0;
    num_illegal    = 0;
    fill_table();

    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;

    for (int i = 0; i < NumRows; i++) begin
      fetch_valid_i <= 1'b1;
      fetch_instr_i <= row_instr[i];
      fetch_pc_i    <= row_pc[i];
      @(posedge clk_i);
      // hold the word until the DUT takes it
      while (!fetch_ready_o) begin
        @(posedge clk_i);
      end
    end
    fetch_valid_i <= 1'b0;
  end

  // random back-pressure with ready about three cycles in four
  initial begin
    void'($urandom(32'h12ae));
    wait (rst_ni === 1'b1);
    forever begin
      @(posedge clk_i);
      commit_ready_i <= ($urandom % 4) != 0;
    end
  end

  // ------------------------------------------------------------------
  // commit monitor
  // ------------------------------------------------------------------
  initial begin
    retired      = 0;
    mismatch_cnt = 0;
    protocol_cnt = 0;
    wait (rst_ni === 1'b1);

    while (retired < NumRows) begin
      @(posedge clk_i);
      if (commit_valid_o && commit_ready_i) begin
        check_field("commit_pc_o", row_pc[retired], commit_pc_o);
        check_field("commit_rd_o", {27'b0, row_rd[retired]}, {27'b0, commit_rd_o});
        check_field("commit_wdata_o", row_wdata[retired], commit_wdata_o);
        check_field("commit_illegal_o", {31'b0, row_illegal[retired]},
                    {31'b0, commit_illegal_o});
        retired++;
      end
    end

    // pipeline must stay empty once the last row retired
    repeat (10) begin
      @(posedge clk_i);
      assert (commit_valid_o === 1'b0) else begin
        $display("unexpected extra commit at t=%0t with pc %h", $time, commit_pc_o);
        protocol_cnt++;
      end
    end

    check_field("instret_o", NumRows, instret_o);
    check_field("illegal_cnt_o", num_illegal, illegal_cnt_o);

    $display("errors: %0d value mismatches, %0d protocol errors", mismatch_cnt, protocol_cnt);
    if (mismatch_cnt == 0 && protocol_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // ------------------------------------------------------------------
  // timeout
  // ------------------------------------------------------------------
  initial begin
    cycles = 0;
    while (cycles < MaxCycles) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout after %0d cycles with %0d of %0d rows retired", cycles, retired, NumRows);
    $display("errors: %0d value mismatches, %0d protocol errors", mismatch_cnt, protocol_cnt + 1);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
isa_pkg.sv
core_pkg.sv
id_stage.sv
issue_stage.sv
ex_stage.sv
commit_stage.sv
core_top.sv
core_tb.sv

// ==== Bender.yml ====
package:
  name: core_pipeline

sources:
  - files:
      - isa_pkg.sv
      - core_pkg.sv
      - id_stage.sv
      - issue_stage.sv
      - ex_stage.sv
      - commit_stage.sv
      - core_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - core_tb.sv
